/* build.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module decodeTb -f cpuDecode.f -o simDecode

simOut=$(./obj_dir/simDecode) || true
echo "$simOut"

if grep -q "=== PASS ===" <<< "$simOut"; then
    exit 0
else
    echo "simulation did not pass"
    exit 1
fi

/* cpuDecode.f */
source/decodePkg.sv
source/pipeReg.sv
source/controlUnit.sv
source/branchUnit.sv
source/registerFile.sv
source/decodeStage.sv
source/decodeTop.sv
verification/decodeChk_chk.sv
verification/decodeTb.sv

/* source/branchUnit.sv */
`timescale 1ns/10ps

module branchUnit import decodePkg::*; #(
    parameter int DATA_W = 16
) (
    input  condE              cond,
    input  flagsT             flags,
    input  logic              branch,
    input  logic              branchReg,
    input  logic [8:0]        offset,    // word offset for B
    input  logic [DATA_W-1:0] regTarget, // forwarded rs for BR
    input  logic [DATA_W-1:0] pc,
    output redirectT          redirect
);

    logic              condMet;
    logic [DATA_W-1:0] offsetExt;
    logic [DATA_W-1:0] relTarget;

    // condition table against execute flags
    always_comb begin
        unique case (cond)
            condNe:     condMet = !flags.zero;
            condEq:     condMet = flags.zero;
            condGt:     condMet = !flags.zero && !flags.neg;
            condLt:     condMet = flags.neg;
            condGte:    condMet = flags.zero || !flags.neg;
            condLte:    condMet = flags.zero || flags.neg;
            condOv:     condMet = flags.overflow;
            condAlways: condMet = 1'b1;
        endcase
    end

    // sign extend, then doubled
    assign offsetExt = {{(DATA_W-10){offset[8]}}, offset, 1'b0};
    assign relTarget = pc + DATA_W'(2) + offsetExt; // relative to next pc

    assign redirect.take   = branch && condMet;
    assign redirect.target = branchReg ? regTarget : relTarget;

endmodule

/* source/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit import decodePkg::*; (
    input  opcodeE opcode,
    output ctrlT   ctrl
);

    always_comb begin
        ctrl          = '0;
        ctrl.regWrite = 1'b1; // most ops write back
        unique case (opcode)
            // register form alu ops
            opAdd, opSub, opXor, opRed, opPaddsb: begin
                ctrl.regDst = 1'b1;
            end
            // shifts take the amount from field C
            opSll, opSra, opRor: begin
                ctrl.regDst = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            opLw: begin
                ctrl.aluSrc    = 1'b1; // base + offset
                ctrl.memEnable = 1'b1;
                ctrl.memToReg  = 1'b1;
            end
            opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.regWrite = 1'b0;
            end
            opLlb, opLhb: begin
                ctrl.memHalf = 1'b1; // byte immediate into half of rd
            end
            opB: begin
                ctrl.branch   = 1'b1;
                ctrl.regWrite = 1'b0;
            end
            opBr: begin
                ctrl.branch    = 1'b1;
                ctrl.branchReg = 1'b1;
                ctrl.regWrite  = 1'b0;
            end
            opPcs: begin
                ctrl.pcSwitch = 1'b1; // rd gets pc+2
            end
            opHlt: begin
                ctrl.regWrite = 1'b0;
            end
        endcase
    end

endmodule

/* source/decodePkg.sv */
package decodePkg;

    localparam int dataWidth = 16; // matches DATA_W at the top

    // 4-bit opcode map
    typedef enum logic [3:0] {
        opAdd    = 4'h0,
        opSub    = 4'h1,
        opXor    = 4'h2,
        opRed    = 4'h3,
        opSll    = 4'h4,
        opSra    = 4'h5,
        opRor    = 4'h6,
        opPaddsb = 4'h7,
        opLw     = 4'h8,
        opSw     = 4'h9,
        opLlb    = 4'hA,
        opLhb    = 4'hB,
        opB      = 4'hC, // pc relative
        opBr     = 4'hD, // register target
        opPcs    = 4'hE,
        opHlt    = 4'hF
    } opcodeE;

    // branch condition, instr[11:9]
    typedef enum logic [2:0] {
        condNe, condEq, condGt, condLt, condGte, condLte, condOv, condAlways
    } condE;

    typedef struct packed {
        logic zero;
        logic overflow;
        logic neg;
    } flagsT;

    // instruction as four nibbles
    typedef struct packed {
        opcodeE     opcode;
        logic [3:0] fieldA; // dst, or cond for branches
        logic [3:0] fieldB;
        logic [3:0] fieldC;
    } instrFieldsT;

    typedef struct packed {
        logic [dataWidth-1:0] instr;
        logic [dataWidth-1:0] pc;
    } ifIdT;

    typedef struct packed {
        logic regDst, aluSrc, memToReg, regWrite, memEnable;
        logic memWrite, memHalf, branch, branchReg, pcSwitch;
    } ctrlT;

    typedef struct packed {
        logic   pcSwitch;
        logic   aluSrc;
        logic   regDst;
        opcodeE opcode;
    } exCtrlT;

    typedef struct packed { logic memEnable; logic memWrite; } memCtrlT;
    typedef struct packed { logic memToReg;  logic regWrite; } wbCtrlT;

    // what execute gets
    typedef struct packed {
        logic [dataWidth-1:0] pc;
        logic [dataWidth-1:0] src1Data;
        logic [dataWidth-1:0] src2Data;
        logic [3:0]           src1, src2, dst;
        logic [dataWidth-1:0] imm;
        exCtrlT               exCtrl;
        memCtrlT              memCtrl;
        wbCtrlT               wbCtrl;
    } idExT;

    typedef struct packed { logic take; logic [dataWidth-1:0] target; } redirectT;

    typedef struct packed {
        logic                 en;
        logic [3:0]           addr;
        logic [dataWidth-1:0] data;
    } regWriteT;

endpackage

/* source/decodeStage.sv */
`timescale 1ns/10ps

module decodeStage import decodePkg::*; #(
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,  // IF/ID holds an instruction
    output logic              inReady,
    input  ifIdT              ifId,
    input  regWriteT          regWr,
    input  logic [3:0]        exDst,
    input  logic [DATA_W-1:0] exResult,
    input  logic              exWrite,
    input  flagsT             flags,
    output redirectT          redirect,
    output logic              outValid,
    input  logic              outReady, // ID/EX can take it
    output idExT              idEx
);

    instrFieldsT       fields;
    ctrlT              ctrl;
    logic [3:0]        src1, src2;
    logic [DATA_W-1:0] rfData1, src1Data, src2Data;
    logic [DATA_W-1:0] imm;
    logic              fwdHit;
    redirectT          brRedirect;

    assign fields = instrFieldsT'(ifId.instr);

    controlUnit ctrlUnit0 (.opcode(fields.opcode), .ctrl(ctrl));

    // rs: LLB/LHB modify rd in place
    assign src1 = ctrl.memHalf ? fields.fieldA : fields.fieldB;
    // rt: SW stores rd, register form uses C
    assign src2 = ctrl.memWrite ? fields.fieldA :
                  (ctrl.regDst ? fields.fieldC : fields.fieldB);

    registerFile #(.DATA_W(DATA_W)) regFile0 (
        .clk(clk), .rstN(rstN),
        .rdAddr1(src1), .rdAddr2(src2),
        .rdData1(rfData1), .rdData2(src2Data),
        .wr(regWr)
    );

    // EX to ID forward on rs only, r0 never forwarded
    assign fwdHit   = exWrite && (exDst != 4'd0) && (exDst == src1);
    assign src1Data = fwdHit ? exResult : rfData1;

    always_comb begin
        if (ctrl.memEnable || ctrl.memWrite) begin
            imm = {{(DATA_W-5){fields.fieldC[3]}}, fields.fieldC, 1'b0}; // halfword offset
        end else if (ctrl.memHalf) begin
            imm = {{(DATA_W-8){1'b0}}, fields.fieldB, fields.fieldC};    // low byte
        end else begin
            imm = {{(DATA_W-4){fields.fieldC[3]}}, fields.fieldC};
        end
    end

    branchUnit #(.DATA_W(DATA_W)) brUnit0 (
        .cond(condE'(fields.fieldA[3:1])), .flags(flags),
        .branch(ctrl.branch), .branchReg(ctrl.branchReg),
        .offset(ifId.instr[8:0]), .regTarget(src1Data), .pc(ifId.pc),
        .redirect(brRedirect)
    );

    // no redirect from a stale IF/ID entry
    assign redirect.take   = brRedirect.take && inValid;
    assign redirect.target = brRedirect.target;

    // combinational stage, handshake goes straight through
    assign outValid = inValid;
    assign inReady  = outReady;

    always_comb begin
        idEx          = '0;
        idEx.pc       = ifId.pc;
        idEx.src1Data = src1Data;
        idEx.src2Data = src2Data;
        idEx.src1     = src1;
        idEx.src2     = src2;
        idEx.dst      = fields.fieldA; // always field A
        idEx.imm      = imm;
        idEx.exCtrl   = '{pcSwitch: ctrl.pcSwitch, aluSrc: ctrl.aluSrc,
                          regDst: ctrl.regDst, opcode: fields.opcode};
        idEx.memCtrl  = '{memEnable: ctrl.memEnable, memWrite: ctrl.memWrite};
        idEx.wbCtrl   = '{memToReg: ctrl.memToReg, regWrite: ctrl.regWrite};
    end

endmodule

/* source/decodeTop.sv */
`timescale 1ns/10ps

module decodeTop import decodePkg::*; #(
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    output logic              inReady,
    input  ifIdT              inPacket,
    input  regWriteT          regWr,    // writeback port
    input  logic [3:0]        exDst,
    input  logic [DATA_W-1:0] exResult,
    input  logic              exWrite,
    input  flagsT             flags,
    output redirectT          redirect, // back to fetch
    output logic              outValid,
    input  logic              outReady,
    output idExT              outPacket
);

    logic ifIdValid, ifIdReady;
    ifIdT ifIdPacket;
    logic idValid, idReady;
    idExT idPacket;

    pipeReg #(.PAYLOAD_T(ifIdT)) ifIdReg (
        .clk(clk), .rstN(rstN),
        .inValid(inValid), .inReady(inReady), .inData(inPacket),
        .outValid(ifIdValid), .outReady(ifIdReady), .outData(ifIdPacket)
    );

    decodeStage #(.DATA_W(DATA_W)) decode0 (
        .clk(clk), .rstN(rstN),
        .inValid(ifIdValid), .inReady(ifIdReady), .ifId(ifIdPacket),
        .regWr(regWr), .exDst(exDst), .exResult(exResult), .exWrite(exWrite),
        .flags(flags), .redirect(redirect),
        .outValid(idValid), .outReady(idReady), .idEx(idPacket)
    );

    pipeReg #(.PAYLOAD_T(idExT)) idExReg (
        .clk(clk), .rstN(rstN),
        .inValid(idValid), .inReady(idReady), .inData(idPacket),
        .outValid(outValid), .outReady(outReady), .outData(outPacket)
    );

endmodule

/* source/pipeReg.sv */
`timescale 1ns/10ps

// one-entry valid/ready stage, full throughput
module pipeReg #(
    parameter type PAYLOAD_T = logic [31:0]
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     inValid,
    output logic     inReady,
    input  PAYLOAD_T inData,
    output logic     outValid,
    input  logic     outReady,
    output PAYLOAD_T outData
);

    // free slot, or the current entry leaves this edge
    assign inReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (inReady) begin
            outValid <= inValid; // refill or drain
        end
    end

    // payload only moves on a real transfer
    always_ff @(posedge clk) begin
        if (inReady && inValid) begin
            outData <= inData;
        end
    end

endmodule

/* source/registerFile.sv */
`timescale 1ns/10ps

module registerFile import decodePkg::*; #(
    parameter int DATA_W = 16
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic [3:0]        rdAddr1,
    input  logic [3:0]        rdAddr2,
    output logic [DATA_W-1:0] rdData1,
    output logic [DATA_W-1:0] rdData2,
    input  regWriteT          wr
);

    localparam int numRegs = 16;

    logic [DATA_W-1:0] regs [numRegs];
    logic              wrLive; // a write that actually lands
    logic              hit1, hit2;

    assign wrLive = wr.en && (wr.addr != 4'd0); // r0 stays zero

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // same-cycle bypass so decode sees writeback data
    assign hit1 = wrLive && (wr.addr == rdAddr1);
    assign hit2 = wrLive && (wr.addr == rdAddr2);

    assign rdData1 = (rdAddr1 == 4'd0) ? '0 : (hit1 ? wr.data : regs[rdAddr1]);
    assign rdData2 = (rdAddr2 == 4'd0) ? '0 : (hit2 ? wr.data : regs[rdAddr2]);

endmodule

/* verification/decodeChk_chk.sv */
`timescale 1ns/10ps

module decodeChk import decodePkg::*; (
    input logic     clk,
    input logic     rstN,
    input logic     outValid,
    input logic     outReady,
    input idExT     outPacket,
    input logic     ifIdValid, // IF/ID occupancy
    input redirectT redirect
);

    // a stalled ID/EX entry must sit still
    stallHoldA: assert property (@(posedge clk) disable iff (!rstN)
        (outValid && !outReady) |=> (outValid && $stable(outPacket)))
        else $error("ID/EX output moved while execute was stalling it");

    resetClearA: assert property (@(posedge clk) !rstN |=> !outValid)
        else $error("outValid high after a reset edge");

    // no redirect from an empty IF/ID slot
    noRedirectA: assert property (@(posedge clk) disable iff (!rstN)
        !ifIdValid |-> !redirect.take)
        else $error("redirect taken with IF/ID empty");

endmodule

bind decodeTop decodeChk chk0 (
    .clk(clk), .rstN(rstN), .outValid(outValid), .outReady(outReady),
    .outPacket(outPacket), .ifIdValid(ifIdValid), .redirect(redirect)
);

/* verification/decodeTb.sv */
`timescale 1ns/10ps

module decodeTb import decodePkg::*; ();

    // stimulus budget, drives the timeout
    localparam int totalItems = 15 + 200 + 200 + 3 * 40 + 8 * 2 * 10 + 16 * 2;
    localparam int cycleLimit = 4 * totalItems + 100;

    logic       clk = 1'b0;
    logic       rstN, inValid, inReady, outValid, outReady, exWrite;
    logic       randomReady; // phase 2 back-pressure on/off
    ifIdT       inPacket;
    regWriteT   regWr;
    logic [3:0] exDst;
    logic [15:0] exResult;
    flagsT      flags;
    redirectT   redirect;
    idExT       outPacket;

    logic [15:0] modelRegs [16];
    idExT        expQ [$];
    idExT        expected;
    int          sentCount = 0;
    int          outCount = 0;
    int          cycleCount = 0;
    logic [31:0] rngMain = 32'd38766;
    logic [31:0] rngReady = ~32'd38766; // separate stream for outReady

    always #2 clk = ~clk;

    decodeTop #(.DATA_W(16)) dut0 (
        .clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady), .inPacket(inPacket),
        .regWr(regWr), .exDst(exDst), .exResult(exResult), .exWrite(exWrite), .flags(flags),
        .redirect(redirect), .outValid(outValid), .outReady(outReady), .outPacket(outPacket)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] nextRand();
        rngMain = xorshift(rngMain);
        return rngMain;
    endfunction

    function automatic ifIdT randPacket(input logic noBranch);
        ifIdT        p;
        logic [31:0] r;
        r = nextRand();
        p.instr = r[15:0];
        p.pc = {r[31:17], 1'b0}; // halfword aligned
        if (noBranch && (p.instr[15:12] == 4'hC || p.instr[15:12] == 4'hD)) begin
            p.instr[14] = 1'b0; // B/BR fold onto LW/SW
        end
        return p;
    endfunction

    // reference decode straight from the opcode table
    function automatic idExT predict(input ifIdT p);
        idExT       e;
        logic [3:0] op, fa, fb, fc;
        logic       regForm;
        op = p.instr[15:12];
        fa = p.instr[11:8];
        fb = p.instr[7:4];
        fc = p.instr[3:0];
        regForm = !op[3]; // opcodes 0..7
        e = '0;
        e.pc = p.pc;
        e.dst = fa;
        e.src1 = (op == 4'hA || op == 4'hB) ? fa : fb;
        if (op == 4'h9) begin
            e.src2 = fa;
        end else begin
            e.src2 = regForm ? fc : fb;
        end
        if (op == 4'h8 || op == 4'h9) begin
            e.imm = {{11{fc[3]}}, fc, 1'b0};
        end else if (op == 4'hA || op == 4'hB) begin
            e.imm = {8'h00, p.instr[7:0]};
        end else begin
            e.imm = {{12{fc[3]}}, fc};
        end
        if (exWrite && exDst != 4'd0 && exDst == e.src1) begin
            e.src1Data = exResult;
        end else begin
            e.src1Data = modelRegs[e.src1];
        end
        e.src2Data = modelRegs[e.src2];
        e.exCtrl.pcSwitch = (op == 4'hE);
        e.exCtrl.aluSrc = (op == 4'h8 || op == 4'h9 || op == 4'h4 || op == 4'h5 || op == 4'h6);
        e.exCtrl.regDst = regForm;
        e.exCtrl.opcode = opcodeE'(op);
        e.memCtrl.memEnable = (op == 4'h8);
        e.memCtrl.memWrite = (op == 4'h9);
        e.wbCtrl.memToReg = (op == 4'h8);
        e.wbCtrl.regWrite = !(op == 4'h9 || op == 4'hC || op == 4'hD || op == 4'hF);
        return e;
    endfunction

    function automatic redirectT branchExpect(input ifIdT p, input flagsT f);
        redirectT    r;
        logic        met;
        logic [15:0] off;
        case (p.instr[11:9])
            3'd0: met = !f.zero;
            3'd1: met = f.zero;
            3'd2: met = !f.zero && !f.neg;
            3'd3: met = f.neg;
            3'd4: met = f.zero || !f.neg;
            3'd5: met = f.zero || f.neg;
            3'd6: met = f.overflow;
            default: met = 1'b1;
        endcase
        off = {{6{p.instr[8]}}, p.instr[8:0], 1'b0}; // words to bytes
        r.take = met && (p.instr[15:12] == 4'hC || p.instr[15:12] == 4'hD);
        if (p.instr[15:12] == 4'hD) begin
            r.target = modelRegs[p.instr[7:4]];
        end else begin
            r.target = p.pc + 16'd2 + off;
        end
        return r;
    endfunction

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkEq(input string what, input logic [95:0] got, input logic [95:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("** Error @ %0t: %s got %h, expected %h", $realtime, what, got, exp));
        end
    endtask

    // called at edge+0.5, returns at edge+0.5 after the input handshake
    task automatic offerInstr(input ifIdT pkt);
        inPacket = pkt;
        inValid = 1'b1;
        @(negedge clk);
        while (!inReady) begin
            @(negedge clk);
        end
        @(posedge clk);
        #0.5;
        inValid = 1'b0;
    endtask

    task automatic pushExpect(input idExT e);
        expQ.push_back(e);
        sentCount++;
    endtask

    task automatic sendInstr(input ifIdT pkt);
        offerInstr(pkt);
        pushExpect(predict(pkt));
    endtask

    task automatic writeReg(input logic [3:0] addr, input logic [15:0] data);
        regWr.en = 1'b1;
        regWr.addr = addr;
        regWr.data = data;
        if (addr != 4'd0) begin
            modelRegs[addr] = data; // r0 stays zero
        end
        @(posedge clk);
        #0.5;
        regWr.en = 1'b0;
    endtask

    task automatic drainPipe();
        do begin
            @(posedge clk);
        end while (outCount != sentCount);
        #0.5;
    endtask

    // output side, compared in order
    always @(negedge clk) begin
        if (rstN && outValid && outReady) begin
            if (expQ.size() == 0) begin
                abortRun("an output packet appeared with nothing expected");
            end else begin
                expected = expQ.pop_front();
                checkEq("outPacket", 96'(outPacket), 96'(expected));
                outCount++;
            end
        end
    end

    always @(posedge clk) begin
        #0.5;
        if (randomReady) begin
            rngReady = xorshift(rngReady);
            outReady = rngReady[0];
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            abortRun($sformatf("timeout: run exceeded %0d cycles", cycleLimit));
        end
    end

    initial begin
        ifIdT        pkt, bp;
        logic [31:0] r;
        $timeformat(-9, 1, " ns", 0);
        rstN = 1'b0;
        inValid = 1'b0;
        inPacket = '0;
        regWr = '0;
        exDst = 4'd0;
        exResult = 16'd0;
        exWrite = 1'b0;
        flags = '0;
        outReady = 1'b1;
        randomReady = 1'b0;
        for (int i = 0; i < 16; i++) begin
            modelRegs[i] = 16'd0;
        end
        repeat (2) @(posedge clk);
        #0.5;
        rstN = 1'b1;

        for (int i = 1; i < 16; i++) begin // preload
            r = nextRand();
            writeReg(4'(i), r[15:0]);
        end

        for (int i = 0; i < 200; i++) begin // full throughput
            sendInstr(randPacket(1'b1));
        end
        drainPipe();

        randomReady = 1'b1; // random back-pressure
        for (int i = 0; i < 200; i++) begin
            sendInstr(randPacket(1'b0));
        end
        drainPipe();
        randomReady = 1'b0;
        outReady = 1'b1;

        // forwarding: hit, r0 destination, write disabled
        for (int k = 0; k < 3; k++) begin
            exWrite = (k != 2);
            exDst = (k == 1) ? 4'd0 : 4'd5;
            exResult = 16'hBEEF;
            for (int i = 0; i < 40; i++) begin
                pkt = randPacket(1'b1);
                if (i % 2 == 0) begin
                    pkt.instr[11:4] = {exDst, exDst}; // src1 lands on exDst
                end
                sendInstr(pkt);
            end
            drainPipe();
        end
        exWrite = 1'b0;

        // branches held in IF/ID behind a stalled filler
        outReady = 1'b0;
        for (int c = 0; c < 8; c++) begin
            for (int br = 0; br < 2; br++) begin
                sendInstr(randPacket(1'b1));
                bp = randPacket(1'b1);
                bp.instr[15:12] = (br == 1) ? 4'hD : 4'hC;
                bp.instr[11:9] = c[2:0];
                sendInstr(bp);
                for (int f = 0; f < 8; f++) begin
                    flags = flagsT'(f[2:0]);
                    @(negedge clk);
                    checkEq("redirect", {79'd0, redirect}, {79'd0, branchExpect(bp, flags)});
                    checkEq("inReady", 96'(inReady), 96'(1'b0)); // both stages full
                    @(posedge clk);
                    #0.5;
                end
                outReady = 1'b1;
                drainPipe();
                outReady = 1'b0;
            end
        end
        outReady = 1'b1;
        flags = '0;

        // writeback in the decode cycle, r0 included
        for (int i = 0; i < 16; i++) begin
            pkt = randPacket(1'b1);
            pkt.instr[15:12] = 4'h0; // ADD reads field B and C
            pkt.instr[7:4] = 4'(i);
            pkt.instr[3:0] = 4'(i);
            offerInstr(pkt);
            r = nextRand();
            writeReg(4'(i), r[15:0]);
            pushExpect(predict(pkt));
            drainPipe();
        end

        if (outCount == sentCount && expQ.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abortRun("number of output packets does not match the instructions sent");
        end
    end

endmodule
